// File: Makefile
TOP := tb_frag_send
SRCS := $(wildcard hdl/*.sv) $(wildcard sim/*.sv) $(wildcard include/*.svh)

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): frag_send.f $(SRCS)
	verilator --binary --timing --assert -f frag_send.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f frag_send.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: frag_send.f
+incdir+include
hdl/frag_cfg_pkg.sv
hdl/frag_types_pkg.sv
hdl/payload_if.sv
hdl/payload_buffer.sv
hdl/frag_planner.sv
hdl/crc16_word.sv
hdl/frame_builder.sv
hdl/frag_send_top.sv
sim/tb_frag_send.sv

// File: hdl/crc16_word.sv
`timescale 1ns/1ps
`default_nettype none

module crc16_word (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  i_clear,
    input  wire logic                  i_en,
    input  wire frag_types_pkg::word_t i_data,
    output frag_types_pkg::crc_t       o_crc
);
    import frag_cfg_pkg::*;
    import frag_types_pkg::*;

    crc_t crc_q;

    // 32 serial steps unrolled, msb of the word first
    function automatic crc_t crc_next(input crc_t c, input word_t d);
        crc_t r;
        logic fb;
        r = c;
        for (int i = 31; i >= 0; i--) begin
            fb = r[15] ^ d[i];
            r  = {r[14:0], 1'b0};
            if (fb) begin
                r = r ^ CRC_POLY;
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_q <= CRC_INIT;
        end else if (i_clear) begin
            crc_q <= CRC_INIT;      // start of a frame
        end else if (i_en) begin
            crc_q <= crc_next(crc_q, i_data);
        end
    end

    assign o_crc = crc_q;

endmodule

`default_nettype wire

// File: hdl/frag_cfg_pkg.sv
`default_nettype none

package frag_cfg_pkg;

    //////////////////////////////
    // sizing
    //////////////////////////////
    localparam int FRAME_WORDS_DEF = 212;     // 848-byte data domain
    localparam int BUF_DEPTH_DEF   = 1024;    // payload words
    localparam int LEN_DEPTH_DEF   = 8;       // queued packets
    localparam int DESC_RING_DEPTH = 4;       // planned fragments

    //////////////////////////////
    // fixed words
    //////////////////////////////
    localparam logic [15:0] CRC_POLY = 16'h1021;
    localparam logic [15:0] CRC_INIT = 16'hffff;
    localparam logic [31:0] PAD_WORD = 32'h5a5a5a5a;    // filler after the crc word

endpackage

`default_nettype wire

// File: hdl/frag_planner.sv
`timescale 1ns/1ps
`default_nettype none

module frag_planner #(
    parameter int FRAME_WORDS = frag_cfg_pkg::FRAME_WORDS_DEF,
    parameter int LEN_DEPTH   = frag_cfg_pkg::LEN_DEPTH_DEF
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  i_len_wr,
    input  wire frag_types_pkg::len_t  i_len,
    output logic                       o_len_full,
    output frag_types_pkg::frag_desc_t o_desc,
    output logic                       o_desc_empty,
    input  wire logic                  i_desc_pop
);
    import frag_cfg_pkg::*;
    import frag_types_pkg::*;

    localparam int   LAW     = $clog2(LEN_DEPTH);
    localparam int   LCW     = $clog2(LEN_DEPTH + 1);
    localparam int   DAW     = $clog2(DESC_RING_DEPTH);
    localparam int   DCW     = $clog2(DESC_RING_DEPTH + 1);
    localparam len_t MAX_PAY = len_t'(FRAME_WORDS - 2);    // header and crc take two

    len_t           len_mem [LEN_DEPTH];
    logic [LAW-1:0] len_wr_ptr;
    logic [LAW-1:0] len_rd_ptr;
    logic [LCW-1:0] len_cnt;
    logic           len_pop;

    len_t           rem;            // words of the current packet not yet planned
    frag_idx_t      idx;

    frag_desc_t     ring [DESC_RING_DEPTH];
    logic [DAW-1:0] ring_wr_ptr;
    logic [DAW-1:0] ring_rd_ptr;
    logic [DCW-1:0] ring_cnt;
    logic           ring_wr;
    logic           split;
    frag_desc_t     next_desc;

    assign len_pop = (rem == '0) && (len_cnt != '0);      // idle with a packet waiting
    assign ring_wr = (rem != '0) && (ring_cnt != DCW'(DESC_RING_DEPTH));
    assign split   = (rem > MAX_PAY);

    assign next_desc.more = split;
    assign next_desc.idx  = idx;
    assign next_desc.len  = split ? MAX_PAY : rem;

    always_ff @(posedge clk) begin
        if (i_len_wr) begin
            len_mem[len_wr_ptr] <= i_len;
        end
        if (ring_wr) begin
            ring[ring_wr_ptr] <= next_desc;
        end
    end

    //////////////////////////////
    // queue pointers and fragment state
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            len_wr_ptr  <= '0;
            len_rd_ptr  <= '0;
            len_cnt     <= '0;
            ring_wr_ptr <= '0;
            ring_rd_ptr <= '0;
            ring_cnt    <= '0;
            rem         <= '0;
            idx         <= '0;
        end else begin
            if (i_len_wr) begin
                len_wr_ptr <= (len_wr_ptr == LAW'(LEN_DEPTH - 1)) ? '0 : len_wr_ptr + 1'b1;
            end
            if (len_pop) begin
                len_rd_ptr <= (len_rd_ptr == LAW'(LEN_DEPTH - 1)) ? '0 : len_rd_ptr + 1'b1;
                rem        <= len_mem[len_rd_ptr];
            end else if (ring_wr) begin
                rem <= rem - next_desc.len;
                idx <= split ? idx + 1'b1 : '0;             // index restarts per packet
            end
            len_cnt <= len_cnt + LCW'(i_len_wr) - LCW'(len_pop);

            if (ring_wr) begin
                ring_wr_ptr <= ring_wr_ptr + 1'b1;
            end
            if (i_desc_pop) begin
                ring_rd_ptr <= ring_rd_ptr + 1'b1;
            end
            ring_cnt <= ring_cnt + DCW'(ring_wr) - DCW'(i_desc_pop);
        end
    end

    assign o_len_full   = (len_cnt == LCW'(LEN_DEPTH));
    assign o_desc       = ring[ring_rd_ptr];
    assign o_desc_empty = (ring_cnt == '0);

    // a zero length would leave its buffered words without a frame
    a_len_nonzero: assert property (@(posedge clk) disable iff (rst)
        i_len_wr |-> (i_len != '0));

endmodule

`default_nettype wire

// File: hdl/frag_send_top.sv
`timescale 1ns/1ps
`default_nettype none

module frag_send_top #(
    parameter int FRAME_WORDS = frag_cfg_pkg::FRAME_WORDS_DEF,
    parameter int BUF_DEPTH   = frag_cfg_pkg::BUF_DEPTH_DEF,
    parameter int LEN_DEPTH   = frag_cfg_pkg::LEN_DEPTH_DEF
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire frag_types_pkg::word_t i_s_tdata,
    input  wire logic                  i_s_tvalid,
    input  wire logic                  i_s_tlast,
    input  wire frag_types_pkg::len_t  i_s_len,
    output logic                       o_s_tready,
    output frag_types_pkg::word_t      o_m_tdata,
    output logic                       o_m_tvalid,
    output logic                       o_m_tlast,
    input  wire logic                  i_m_tready
);
    import frag_types_pkg::*;

    logic       buf_full;
    logic       len_full;
    logic       s_accept;
    logic       len_wr;
    frag_desc_t desc;
    logic       desc_empty;
    logic       desc_pop;

    payload_if pl_if ();

    assign o_s_tready = !buf_full && !len_full;    // room for the word and its length
    assign s_accept   = i_s_tvalid && o_s_tready;
    assign len_wr     = s_accept && i_s_tlast;     // length rides on the last beat

    payload_buffer #(
        .DEPTH (BUF_DEPTH)
    ) u_buf (
        .clk    (clk),
        .rst    (rst),
        .i_wr   (s_accept),
        .i_data (i_s_tdata),
        .i_last (i_s_tlast),
        .o_full (buf_full),
        .pl     (pl_if.source)
    );

    frag_planner #(
        .FRAME_WORDS (FRAME_WORDS),
        .LEN_DEPTH   (LEN_DEPTH)
    ) u_plan (
        .clk          (clk),
        .rst          (rst),
        .i_len_wr     (len_wr),
        .i_len        (i_s_len),
        .o_len_full   (len_full),
        .o_desc       (desc),
        .o_desc_empty (desc_empty),
        .i_desc_pop   (desc_pop)
    );

    frame_builder #(
        .FRAME_WORDS (FRAME_WORDS)
    ) u_build (
        .clk          (clk),
        .rst          (rst),
        .i_desc       (desc),
        .i_desc_empty (desc_empty),
        .o_desc_pop   (desc_pop),
        .pl           (pl_if.sink),
        .o_m_tdata    (o_m_tdata),
        .o_m_tvalid   (o_m_tvalid),
        .o_m_tlast    (o_m_tlast),
        .i_m_tready   (i_m_tready)
    );

endmodule

`default_nettype wire

// File: hdl/frag_types_pkg.sv
`default_nettype none

package frag_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [11:0] len_t;         // counts words
    typedef logic [6:0]  frag_idx_t;
    typedef logic [15:0] crc_t;

    // one fragment of a packet, one frame on the output
    typedef struct packed {
        logic      more;                // further fragments follow
        frag_idx_t idx;
        len_t      len;                 // payload words in this frame
    } frag_desc_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEAD,
        ST_PAY,
        ST_CRC,
        ST_PAD
    } build_state_t;

endpackage

`default_nettype wire

// File: hdl/frame_builder.sv
`timescale 1ns/1ps
`default_nettype none

module frame_builder #(
    parameter int FRAME_WORDS = frag_cfg_pkg::FRAME_WORDS_DEF
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire frag_types_pkg::frag_desc_t i_desc,
    input  wire logic                       i_desc_empty,
    output logic                            o_desc_pop,
    payload_if.sink                         pl,
    output frag_types_pkg::word_t           o_m_tdata,
    output logic                            o_m_tvalid,
    output logic                            o_m_tlast,
    input  wire logic                       i_m_tready
);
    import frag_cfg_pkg::*;
    import frag_types_pkg::*;

    localparam len_t MAX_PAY = len_t'(FRAME_WORDS - 2);

    build_state_t state;
    frag_desc_t   desc_q;       // held for the whole frame
    len_t         cnt;          // words sent in the payload or filler phase
    len_t         pad_len;
    logic         accept;
    logic         pay_end;
    logic         pad_end;
    logic         crc_en;
    crc_t         crc;
    word_t        head_word;

    assign pad_len    = MAX_PAY - desc_q.len;
    assign pay_end    = (cnt == desc_q.len - 1'b1);
    assign pad_end    = (cnt == pad_len - 1'b1);
    assign head_word  = {desc_q.more, desc_q.idx, 12'h000, desc_q.len};
    assign accept     = o_m_tvalid && i_m_tready;
    assign o_desc_pop = (state == ST_IDLE) && !i_desc_empty;
    assign crc_en     = accept && ((state == ST_HEAD) || (state == ST_PAY));

    always_ff @(posedge clk) begin
        if (o_desc_pop) begin
            desc_q <= i_desc;
        end
    end

    //////////////////////////////
    // output mux
    //////////////////////////////
    always_comb begin
        o_m_tvalid = 1'b0;
        o_m_tlast  = 1'b0;
        o_m_tdata  = PAD_WORD;
        pl.pop     = 1'b0;
        case (state)
            ST_HEAD: begin
                o_m_tvalid = 1'b1;
                o_m_tdata  = head_word;
            end
            ST_PAY: begin
                o_m_tvalid = !pl.empty;                 // bubble until the buffer catches up
                o_m_tdata  = pl.data;
                pl.pop     = !pl.empty && i_m_tready;
            end
            ST_CRC: begin
                o_m_tvalid = 1'b1;
                o_m_tdata  = {16'h0000, crc};
                o_m_tlast  = (pad_len == '0);           // full-size fragment, no filler
            end
            ST_PAD: begin
                o_m_tvalid = 1'b1;
                o_m_tlast  = pad_end;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    cnt <= '0;
                    if (o_desc_pop) begin
                        state <= ST_HEAD;
                    end
                end
                ST_HEAD: begin
                    if (accept) begin
                        state <= ST_PAY;
                    end
                end
                ST_PAY: begin
                    if (accept) begin
                        cnt <= pay_end ? '0 : cnt + 1'b1;
                        if (pay_end) begin
                            state <= ST_CRC;
                        end
                    end
                end
                ST_CRC: begin
                    if (accept) begin
                        state <= (pad_len == '0) ? ST_IDLE : ST_PAD;
                    end
                end
                ST_PAD: begin
                    if (accept) begin
                        cnt <= cnt + 1'b1;
                        if (pad_end) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    crc16_word u_crc (
        .clk     (clk),
        .rst     (rst),
        .i_clear (o_desc_pop),
        .i_en    (crc_en),
        .i_data  (o_m_tdata),
        .o_crc   (crc)
    );

    // packet boundaries in the buffer line up with the planner's cuts
    a_last_flag: assert property (@(posedge clk) disable iff (rst)
        pl.pop |-> (pl.last == (pay_end && !desc_q.more)));

    a_hold: assert property (@(posedge clk) disable iff (rst)
        (o_m_tvalid && !i_m_tready) |=>
            (o_m_tvalid && $stable(o_m_tdata) && $stable(o_m_tlast)));

endmodule

`default_nettype wire

// File: hdl/payload_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module payload_buffer #(
    parameter int DEPTH = frag_cfg_pkg::BUF_DEPTH_DEF
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  i_wr,
    input  wire frag_types_pkg::word_t i_data,
    input  wire logic                  i_last,
    output logic                       o_full,
    payload_if.source                  pl
);
    import frag_types_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    word_t         mem_data [DEPTH];
    logic          mem_last [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem_data[wr_ptr] <= i_data;
            mem_last[wr_ptr] <= i_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pl.pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(i_wr) - CW'(pl.pop);
        end
    end

    // head word shows as soon as count moves off zero
    assign o_full   = (count == CW'(DEPTH));
    assign pl.empty = (count == '0);
    assign pl.data  = mem_data[rd_ptr];
    assign pl.last  = mem_last[rd_ptr];

    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        !(i_wr && o_full) && !(pl.pop && pl.empty));

endmodule

`default_nettype wire

// File: hdl/payload_if.sv
`timescale 1ns/1ps
`default_nettype none

interface payload_if;
    import frag_types_pkg::*;

    word_t data;        // oldest buffered word
    logic  last;        // final word of its packet
    logic  empty;
    logic  pop;         // drops the head word on the edge

    modport source (output data, output last, output empty, input pop);
    modport sink   (input data, input last, input empty, output pop);

endinterface

`default_nettype wire

// File: include/frag_tb_util.svh
`ifndef FRAG_TB_UTIL_SVH
`define FRAG_TB_UTIL_SVH

// crc-16 over one word taken msb first
function automatic logic [15:0] crc_update_word(input logic [15:0] crc, input logic [31:0] data);
    logic [15:0] c;
    c = crc;
    for (int i = 31; i >= 0; i--) begin
        c = (c[15] ^ data[i]) ? ({c[14:0], 1'b0} ^ frag_cfg_pkg::CRC_POLY) : {c[14:0], 1'b0};
    end
    return c;
endfunction

// more flag, index, zero field, length
function automatic logic [31:0] header_word(input bit more, input int idx, input int len);
    return {more, 7'(idx), 12'h000, 12'(len)};
endfunction

// appends every frame of one packet to the expected-word queue
function automatic void expand_packet(input logic [31:0] pay[$], input int frame_words,
                                      ref logic [31:0] exp_q[$]);
    int          off;
    int          idx;
    int          len;
    logic [15:0] crc;
    logic [31:0] head;
    off = 0;
    idx = 0;
    while (off < pay.size()) begin
        len  = (pay.size() - off > frame_words - 2) ? frame_words - 2 : pay.size() - off;
        head = header_word(off + len < pay.size(), idx, len);
        crc  = crc_update_word(frag_cfg_pkg::CRC_INIT, head);
        exp_q.push_back(head);
        for (int i = 0; i < len; i++) begin
            crc = crc_update_word(crc, pay[off + i]);
            exp_q.push_back(pay[off + i]);
        end
        exp_q.push_back({16'h0000, crc});
        for (int i = len; i < frame_words - 2; i++) begin
            exp_q.push_back(frag_cfg_pkg::PAD_WORD);
        end
        off += len;
        idx++;
    end
endfunction

`endif

// File: sim/tb_frag_send.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frag_send;
    import frag_types_pkg::*;

    `include "frag_tb_util.svh"

    localparam int FRAME_WORDS = 16;
    localparam int NUM_PKTS    = 30;
    localparam int MAX_PAY     = FRAME_WORDS - 2;

    logic        clk;
    logic        rst;
    word_t       i_s_tdata;
    logic        i_s_tvalid;
    logic        i_s_tlast;
    len_t        i_s_len;
    logic        o_s_tready;
    word_t       o_m_tdata;
    logic        o_m_tvalid;
    logic        o_m_tlast;
    logic        i_m_tready;

    logic [31:0] exp_q[$];          // expected output words oldest first
    int          pkt_len [NUM_PKTS];
    int          beat_cnt;          // position inside the current frame
    int          cycle;
    int          limit_cycles;

    frag_send_top #(
        .FRAME_WORDS (FRAME_WORDS)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .i_s_tdata  (i_s_tdata),
        .i_s_tvalid (i_s_tvalid),
        .i_s_tlast  (i_s_tlast),
        .i_s_len    (i_s_len),
        .o_s_tready (o_s_tready),
        .o_m_tdata  (o_m_tdata),
        .o_m_tvalid (o_m_tvalid),
        .o_m_tlast  (o_m_tlast),
        .i_m_tready (i_m_tready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // one packet with random gaps in valid, then its frames go to the queue
    task automatic send_packet(input int len);
        logic [31:0] pay[$];
        int          sent;
        for (int i = 0; i < len; i++) begin
            pay.push_back($urandom());
        end
        sent = 0;
        while (sent < len) begin
            i_s_tvalid = ($urandom_range(3, 0) != 0);
            i_s_tdata  = pay[sent];
            i_s_tlast  = (sent == len - 1);
            i_s_len    = len_t'(len);
            @(posedge clk);
            if (i_s_tvalid && o_s_tready) begin
                sent++;
            end
            #1;
        end
        i_s_tvalid = 1'b0;
        i_s_tlast  = 1'b0;
        expand_packet(pay, FRAME_WORDS, exp_q);
    endtask

    //////////////////////////////
    // output side
    //////////////////////////////
    always @(posedge clk) begin
        #1;
        i_m_tready = ($urandom_range(9, 0) < 7);    // roughly 70 percent ready
    end

    always @(posedge clk) begin
        logic [31:0] exp_word;
        if (!rst && o_m_tvalid && i_m_tready) begin
            assert (exp_q.size() > 0)
                else fail_run("an output beat arrived while no frame was expected");
            exp_word = exp_q.pop_front();
            assert (o_m_tdata == exp_word)
                else fail_run($sformatf("ERROR o_m_tdata expected %08h got %08h",
                                        exp_word, o_m_tdata));
            assert (o_m_tlast == (beat_cnt == FRAME_WORDS - 1))
                else fail_run($sformatf("ERROR o_m_tlast expected %0h got %0h",
                                        (beat_cnt == FRAME_WORDS - 1), o_m_tlast));
            beat_cnt = (beat_cnt == FRAME_WORDS - 1) ? 0 : beat_cnt + 1;
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        (cycle >= 1 && $past(rst)) |-> (!o_m_tvalid && !o_m_tlast && o_s_tready))
        else fail_run("output valid or input not ready around reset");

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (o_m_tvalid && !i_m_tready) |=>
            (o_m_tvalid && $stable(o_m_tdata) && $stable(o_m_tlast)))
        else fail_run("output beat changed while stalled by i_m_tready");

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        fail_run("the run timed out before all frames came out");
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        int total_words;
        void'($urandom(33));
        clk          = 1'b0;
        rst          = 1'b1;
        i_s_tdata    = '0;
        i_s_tvalid   = 1'b0;
        i_s_tlast    = 1'b0;
        i_s_len      = '0;
        i_m_tready   = 1'b1;
        beat_cnt     = 0;
        cycle        = 0;
        limit_cycles = 0;
        total_words  = 0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            pkt_len[p]  = $urandom_range(40, 1);
            total_words += ((pkt_len[p] + MAX_PAY - 1) / MAX_PAY) * FRAME_WORDS;
        end
        limit_cycles = 40 * total_words + 1000;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int p = 0; p < NUM_PKTS; p++) begin
            send_packet(pkt_len[p]);
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (50) @(posedge clk);     // catch stray beats after the last frame

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
